/* rtl/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// datapath widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// l1d geometry, one word per line
`define LSU_L1D_LINES 4
`define LSU_L1D_IDX_W 2
`define LSU_TAG_W (`LSU_ADDR_W - `LSU_L1D_IDX_W - 2)

// cacheable windows, lower bound inclusive, upper bound exclusive
`define LSU_CACHE_LO0 32'h3000_0000
`define LSU_CACHE_HI0 32'h4000_0000
`define LSU_CACHE_LO1 32'h8000_0000
`define LSU_CACHE_HI1 32'h8040_0000

`endif

/* rtl/lsu_pkg.sv */
`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

  typedef enum logic [3:0] {
    LSU_OP_NONE = 4'd0,
    LSU_OP_LB   = 4'd1,
    LSU_OP_LBU  = 4'd2,
    LSU_OP_LH   = 4'd3,
    LSU_OP_LHU  = 4'd4,
    LSU_OP_LW   = 4'd5,
    LSU_OP_SB   = 4'd6,
    LSU_OP_SH   = 4'd7,
    LSU_OP_SW   = 4'd8
  } lsu_op_e;

  // request as held by the execute stage
  typedef struct packed {
    lsu_op_e                op;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic                      is_load;
    logic                      is_store;
    logic [1:0]                byte_off;
    logic [3:0]                strb;
    logic [`LSU_DATA_W-1:0]    wdata;
    logic [`LSU_TAG_W-1:0]     tag;
    logic [`LSU_L1D_IDX_W-1:0] idx;
    logic                      cacheable;
    lsu_op_e                   op;
  } lsu_dec_t;

  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    logic [3:0]             strb;
  } lsu_rd_bus_t;

  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] data;
    logic [3:0]             strb;
  } lsu_wr_bus_t;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_RD_WAIT = 2'd1,
    ST_WR_WAIT = 2'd2,
    ST_DONE    = 2'd3
  } lsu_state_e;

endpackage

`default_nettype wire

/* rtl/lsu_req_decode.sv */
`default_nettype none

`include "lsu_config.svh"

module lsu_req_decode
  import lsu_pkg::*;
(
  input  lsu_req_t req_i,
  output lsu_dec_t dec_o
);

  logic [`LSU_ADDR_W-1:0] addr;
  logic [1:0]             off;
  logic [3:0]             size_mask;
  logic [3:0]             strb;
  logic [`LSU_DATA_W-1:0] wdata_sh;
  logic [`LSU_DATA_W-1:0] wdata_lane;
  logic                   in_win0;
  logic                   in_win1;

  assign addr = req_i.addr;
  assign off  = addr[1:0];

  // access size as a lane mask at offset zero
  always_comb begin
    case (req_i.op)
      LSU_OP_LB, LSU_OP_LBU, LSU_OP_SB: size_mask = 4'b0001;
      LSU_OP_LH, LSU_OP_LHU, LSU_OP_SH: size_mask = 4'b0011;
      LSU_OP_LW, LSU_OP_SW:             size_mask = 4'b1111;
      default:                          size_mask = 4'b0000;
    endcase
  end

  assign strb     = size_mask << off;
  assign wdata_sh = req_i.wdata << {off, 3'b000};

  // unused lanes driven to zero
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wdata_lane[8*i +: 8] = strb[i] ? wdata_sh[8*i +: 8] : 8'h00;
    end
  end

  assign in_win0 = (addr >= `LSU_CACHE_LO0) && (addr < `LSU_CACHE_HI0);
  assign in_win1 = (addr >= `LSU_CACHE_LO1) && (addr < `LSU_CACHE_HI1);

  always_comb begin
    dec_o           = '0;
    dec_o.is_load   = req_i.op inside {LSU_OP_LB, LSU_OP_LBU, LSU_OP_LH,
                                       LSU_OP_LHU, LSU_OP_LW};
    dec_o.is_store  = req_i.op inside {LSU_OP_SB, LSU_OP_SH, LSU_OP_SW};
    dec_o.byte_off  = off;
    dec_o.strb      = strb;
    dec_o.wdata     = wdata_lane;
    dec_o.tag       = addr[`LSU_ADDR_W-1 -: `LSU_TAG_W];
    dec_o.idx       = addr[`LSU_L1D_IDX_W+1:2];
    dec_o.cacheable = in_win0 || in_win1;
    dec_o.op        = req_i.op;
  end

endmodule

`default_nettype wire

/* rtl/lsu_l1d_cache.sv */
`default_nettype none

`include "lsu_config.svh"

module lsu_l1d_cache
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  lsu_dec_t               dec_i,
  input  logic                   fill_en_i,
  input  logic [`LSU_DATA_W-1:0] fill_data_i,
  input  logic                   inval_en_i,
  output logic                   hit_o,
  output logic [`LSU_DATA_W-1:0] hit_data_o
);

  logic [`LSU_DATA_W-1:0]    data_q [`LSU_L1D_LINES];
  logic [`LSU_TAG_W-1:0]     tag_q  [`LSU_L1D_LINES];
  logic [`LSU_L1D_LINES-1:0] valid_q;
  logic                      tag_match;

  // line holds the word addressed by the current request
  assign tag_match = valid_q[dec_i.idx] && (tag_q[dec_i.idx] == dec_i.tag);

  assign hit_o      = dec_i.is_load && dec_i.cacheable && tag_match;
  assign hit_data_o = data_q[dec_i.idx];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (fill_en_i) begin
      valid_q[dec_i.idx] <= 1'b1;
    end else if (inval_en_i && tag_match) begin
      // store to a cached word drops the line
      valid_q[dec_i.idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en_i) begin
      data_q[dec_i.idx] <= fill_data_i;
      tag_q[dec_i.idx]  <= dec_i.tag;
    end
  end

endmodule

`default_nettype wire

/* rtl/lsu_bus_ctrl.sv */
`default_nettype none

`include "lsu_config.svh"

module lsu_bus_ctrl
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  input  lsu_dec_t               dec_i,
  input  logic                   hit_i,
  input  logic [`LSU_DATA_W-1:0] hit_data_i,
  input  logic                   rvalid_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  input  logic                   wready_i,
  output logic                   arvalid_o,
  output lsu_rd_bus_t            ar_o,
  output logic                   awvalid_o,
  output lsu_wr_bus_t            aw_o,
  output logic                   fill_en_o,
  output logic [`LSU_DATA_W-1:0] fill_data_o,
  output logic                   inval_en_o,
  output logic [`LSU_DATA_W-1:0] word_o,
  output logic                   done_load_o,
  output logic                   done_store_o
);

  lsu_state_e             state_q;
  lsu_state_e             state_d;
  logic [`LSU_DATA_W-1:0] word_q;
  logic                   done_load_q;
  logic                   done_store_q;
  logic                   accept;
  logic                   hit_take;
  logic                   rd_take;
  logic                   wr_take;
  logic [`LSU_ADDR_W-1:0] word_addr;

  assign accept   = (state_q == ST_IDLE) && req_valid_i;
  assign hit_take = accept && dec_i.is_load && hit_i;
  assign rd_take  = (state_q == ST_RD_WAIT) && rvalid_i;
  assign wr_take  = (state_q == ST_WR_WAIT) && wready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (hit_take) begin
          state_d = ST_DONE;
        end else if (accept && dec_i.is_load) begin
          state_d = ST_RD_WAIT;
        end else if (accept && dec_i.is_store) begin
          state_d = ST_WR_WAIT;
        end
      end
      ST_RD_WAIT: if (rvalid_i) state_d = ST_DONE;
      ST_WR_WAIT: if (wready_i) state_d = ST_DONE;
      // one cycle to let the execute stage move on
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      done_load_q  <= 1'b0;
      done_store_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      done_load_q  <= hit_take || rd_take;
      done_store_q <= wr_take;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_take) begin
      word_q <= hit_data_i;
    end else if (rd_take) begin
      word_q <= rdata_i;
    end
  end

  assign word_addr = {dec_i.tag, dec_i.idx, 2'b00};

  // levels follow the wait states
  assign arvalid_o = (state_q == ST_RD_WAIT);
  assign awvalid_o = (state_q == ST_WR_WAIT);

  assign ar_o.addr = word_addr;
  assign ar_o.strb = dec_i.strb;
  assign aw_o.addr = word_addr;
  assign aw_o.data = dec_i.wdata;
  assign aw_o.strb = dec_i.strb;

  assign fill_en_o   = rd_take && dec_i.cacheable;
  assign fill_data_o = rdata_i;
  assign inval_en_o  = accept && dec_i.is_store;

  assign word_o       = word_q;
  assign done_load_o  = done_load_q;
  assign done_store_o = done_store_q;

endmodule

`default_nettype wire

/* rtl/lsu_load_align.sv */
`default_nettype none

`include "lsu_config.svh"

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic [`LSU_DATA_W-1:0] word_i,
  input  lsu_dec_t               dec_i,
  input  logic                   done_load_i,
  output logic                   rvalid_o,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  logic [`LSU_DATA_W-1:0] shifted;

  // addressed byte down to lane zero
  assign shifted = word_i >> {dec_i.byte_off, 3'b000};

  always_comb begin
    case (dec_i.op)
      LSU_OP_LB: begin
        rdata_o = {{(`LSU_DATA_W-8){shifted[7]}}, shifted[7:0]};
      end
      LSU_OP_LBU: begin
        rdata_o = {{(`LSU_DATA_W-8){1'b0}}, shifted[7:0]};
      end
      LSU_OP_LH: begin
        rdata_o = {{(`LSU_DATA_W-16){shifted[15]}}, shifted[15:0]};
      end
      LSU_OP_LHU: begin
        rdata_o = {{(`LSU_DATA_W-16){1'b0}}, shifted[15:0]};
      end
      LSU_OP_LW: rdata_o = shifted;
      default:   rdata_o = '0;
    endcase
  end

  assign rvalid_o = done_load_i;

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
`default_nettype none

`include "lsu_config.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  input  lsu_req_t               req_i,
  input  logic                   rvalid_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  input  logic                   wready_i,
  output logic                   rvalid_o,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   wdone_o,
  output logic                   arvalid_o,
  output lsu_rd_bus_t            ar_o,
  output logic                   awvalid_o,
  output lsu_wr_bus_t            aw_o
);

  lsu_dec_t               dec;
  logic                   hit;
  logic [`LSU_DATA_W-1:0] hit_data;
  logic                   fill_en;
  logic [`LSU_DATA_W-1:0] fill_data;
  logic                   inval_en;
  logic [`LSU_DATA_W-1:0] word;
  logic                   done_load;

  lsu_req_decode u_decode (
    .req_i (req_i),
    .dec_o (dec)
  );

  lsu_l1d_cache u_l1d (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .dec_i       (dec),
    .fill_en_i   (fill_en),
    .fill_data_i (fill_data),
    .inval_en_i  (inval_en),
    .hit_o       (hit),
    .hit_data_o  (hit_data)
  );

  lsu_bus_ctrl u_bus_ctrl (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .dec_i        (dec),
    .hit_i        (hit),
    .hit_data_i   (hit_data),
    .rvalid_i     (rvalid_i),
    .rdata_i      (rdata_i),
    .wready_i     (wready_i),
    .arvalid_o    (arvalid_o),
    .ar_o         (ar_o),
    .awvalid_o    (awvalid_o),
    .aw_o         (aw_o),
    .fill_en_o    (fill_en),
    .fill_data_o  (fill_data),
    .inval_en_o   (inval_en),
    .word_o       (word),
    .done_load_o  (done_load),
    .done_store_o (wdone_o)
  );

  lsu_load_align u_align (
    .word_i      (word),
    .dec_i       (dec),
    .done_load_i (done_load),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o)
  );

endmodule

`default_nettype wire

/* verification/lsu_props.sv */
`default_nettype none

module lsu_props (
  input logic clk,
  input logic rst_n_i,
  input logic arvalid_o,
  input logic awvalid_o,
  input logic rvalid_o,
  input logic wdone_o,
  input logic rvalid_i,
  input logic wready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // one bus direction at a time
  bus_exclusive_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(arvalid_o && awvalid_o))
    else $error("arvalid_o and awvalid_o high in the same cycle");

  ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    arvalid_o && !rvalid_i |=> arvalid_o)
    else $error("arvalid_o dropped before rvalid_i");

  aw_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    awvalid_o && !wready_i |=> awvalid_o)
    else $error("awvalid_o dropped before wready_i");

  // completion strobes are single pulses
  rvalid_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    rvalid_o |=> !rvalid_o)
    else $error("rvalid_o high for more than one cycle");

  wdone_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    wdone_o |=> !wdone_o)
    else $error("wdone_o high for more than one cycle");

  reset_quiet_a: assert property (@(posedge clk)
    !rst_n_i |-> !(arvalid_o || awvalid_o || rvalid_o || wdone_o))
    else $error("valid output high while in reset");

endmodule

`default_nettype wire

/* verification/lsu_tb.sv */
`default_nettype none

`include "lsu_config.svh"

module lsu_tb
  import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REQS    = 400;
  localparam int REQ_TIMEOUT = 40;

  logic                   clk;
  logic                   rst_n_i;
  logic                   req_valid_i;
  lsu_req_t               req_i;
  logic                   rvalid_i;
  logic [`LSU_DATA_W-1:0] rdata_i;
  logic                   wready_i;
  logic                   rvalid_o;
  logic [`LSU_DATA_W-1:0] rdata_o;
  logic                   wdone_o;
  logic                   arvalid_o;
  lsu_rd_bus_t            ar_o;
  logic                   awvalid_o;
  lsu_wr_bus_t            aw_o;

  logic [31:0] lfsr;
  int          err_cnt;
  int          chk_cnt;
  logic        timed_out;

  // bus memory and reference shadow, both keyed by word address
  logic [31:0] bus_mem [logic [31:0]];
  logic [31:0] shadow_mem [logic [31:0]];
  logic [27:0] shadow_tag [4];
  logic [3:0]  shadow_valid;

  lsu_top DUT (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .rvalid_i    (rvalid_i),
    .rdata_i     (rdata_i),
    .wready_i    (wready_i),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .wdone_o     (wdone_o),
    .arvalid_o   (arvalid_o),
    .ar_o        (ar_o),
    .awvalid_o   (awvalid_o),
    .aw_o        (aw_o)
  );

  bind lsu_top lsu_props u_props (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .arvalid_o (arvalid_o),
    .awvalid_o (awvalid_o),
    .rvalid_o  (rvalid_o),
    .wdone_o   (wdone_o),
    .rvalid_i  (rvalid_i),
    .wready_i  (wready_i)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // contents of a word never written
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h6b1d_93e5;
  endfunction

  function automatic logic [31:0] shadow_word(input logic [31:0] a);
    return shadow_mem.exists(a) ? shadow_mem[a] : fill_word(a);
  endfunction

  function automatic logic [31:0] bus_word(input logic [31:0] a);
    return bus_mem.exists(a) ? bus_mem[a] : fill_word(a);
  endfunction

  function automatic logic is_cacheable(input logic [31:0] a);
    return (a >= `LSU_CACHE_LO0 && a < `LSU_CACHE_HI0) ||
           (a >= `LSU_CACHE_LO1 && a < `LSU_CACHE_HI1);
  endfunction

  function automatic logic [31:0] load_result(input lsu_op_e op, input logic [31:0] w,
                                              input logic [1:0] off);
    logic [31:0] s;
    s = w >> (8 * off);
    case (op)
      LSU_OP_LB:  return {{24{s[7]}}, s[7:0]};
      LSU_OP_LBU: return {24'h0, s[7:0]};
      LSU_OP_LH:  return {{16{s[15]}}, s[15:0]};
      LSU_OP_LHU: return {16'h0, s[15:0]};
      default:    return s;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t %s actual 0x%08h expected 0x%08h", $time, name, act, exp);
    end
  endtask

  task automatic run_req(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                         input int delay);
    logic [31:0] wa;
    logic [1:0]  off;
    logic [1:0]  idx;
    logic        is_load;
    logic        exp_hit;
    logic [3:0]  strb;
    logic [31:0] lanes;
    logic [31:0] merged;
    logic        resp_sent;
    logic        done;
    int          cyc;
    int          waited;
    wa      = {addr[31:2], 2'b00};
    off     = addr[1:0];
    idx     = addr[3:2];
    is_load = op inside {LSU_OP_LB, LSU_OP_LBU, LSU_OP_LH, LSU_OP_LHU, LSU_OP_LW};
    exp_hit = is_load && is_cacheable(addr) && shadow_valid[idx] && shadow_tag[idx] == addr[31:4];
    strb    = (op inside {LSU_OP_LB, LSU_OP_LBU, LSU_OP_SB}) ? 4'b0001 :
              (op inside {LSU_OP_LH, LSU_OP_LHU, LSU_OP_SH}) ? 4'b0011 : 4'b1111;
    strb    = strb << off;
    lanes   = wdata << (8 * off);
    for (int i = 0; i < 4; i++) begin
      if (!strb[i]) lanes[8*i +: 8] = 8'h00;
    end
    req_i       = '{op: op, addr: addr, wdata: wdata};
    req_valid_i = 1'b1;
    resp_sent   = 1'b0;
    done        = 1'b0;
    cyc         = 0;
    waited      = 0;
    while (!done && cyc < REQ_TIMEOUT) begin
      @(posedge clk);
      #1;
      cyc++;
      if (exp_hit) begin
        // hit answers in the first cycle with no bus read
        check_val("arvalid_o", arvalid_o, 0);
        check_val("rvalid_o", rvalid_o, 1);
        check_val("wdone_o", wdone_o, 0);
        check_val("rdata_o", rdata_o, load_result(op, shadow_word(wa), off));
        done = 1'b1;
      end else if (resp_sent) begin
        rvalid_i = 1'b0;
        wready_i = 1'b0;
        check_val("arvalid_o", arvalid_o, 0);
        check_val("awvalid_o", awvalid_o, 0);
        if (is_load) begin
          check_val("rvalid_o", rvalid_o, 1);
          check_val("wdone_o", wdone_o, 0);
          check_val("rdata_o", rdata_o, load_result(op, shadow_word(wa), off));
          if (is_cacheable(addr)) begin
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx]   = addr[31:4];
          end
        end else begin
          check_val("wdone_o", wdone_o, 1);
          check_val("rvalid_o", rvalid_o, 0);
          if (shadow_valid[idx] && shadow_tag[idx] == addr[31:4]) shadow_valid[idx] = 1'b0;
          merged = shadow_word(wa);
          for (int i = 0; i < 4; i++) begin
            if (strb[i]) merged[8*i +: 8] = lanes[8*i +: 8];
          end
          shadow_mem[wa] = merged;
        end
        done = 1'b1;
      end else begin
        // levels held while the bus stalls
        check_val("arvalid_o", arvalid_o, is_load);
        check_val("awvalid_o", awvalid_o, !is_load);
        check_val("rvalid_o", rvalid_o, 0);
        check_val("wdone_o", wdone_o, 0);
        if (cyc == 1 && is_load) begin
          check_val("ar_o.addr", ar_o.addr, wa);
          check_val("ar_o.strb", ar_o.strb, strb);
        end else if (cyc == 1) begin
          check_val("aw_o.addr", aw_o.addr, wa);
          check_val("aw_o.strb", aw_o.strb, strb);
          check_val("aw_o.data", aw_o.data, lanes);
        end
        if (waited == delay && is_load) begin
          rdata_i   = bus_word(ar_o.addr);
          rvalid_i  = 1'b1;
          resp_sent = 1'b1;
        end else if (waited == delay) begin
          merged = bus_word(aw_o.addr);
          for (int i = 0; i < 4; i++) begin
            if (aw_o.strb[i]) merged[8*i +: 8] = aw_o.data[8*i +: 8];
          end
          bus_mem[aw_o.addr] = merged;
          wready_i  = 1'b1;
          resp_sent = 1'b1;
        end else begin
          waited++;
        end
      end
    end
    if (!done) begin
      $display("request %s to 0x%08h got no completion in time", op.name(), addr);
      err_cnt++;
      timed_out = 1'b1;
    end else begin
      @(posedge clk);
      #1;
      check_val("rvalid_o", rvalid_o, 0);
      check_val("wdone_o", wdone_o, 0);
      req_valid_i = 1'b0;
    end
  endtask

  initial begin
    logic [3:0]  op_bits;
    logic [31:0] base;
    logic [31:0] addr;
    logic [1:0]  off;
    clk          = 1'b0;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    rvalid_i     = 1'b0;
    rdata_i      = '0;
    wready_i     = 1'b0;
    lfsr         = 32'h274ce229;
    err_cnt      = 0;
    chk_cnt      = 0;
    timed_out    = 1'b0;
    shadow_valid = '0;
    for (int c = 0; c < 4; c++) begin
      @(posedge clk);
      #1;
      if (c == 2) rst_n_i = 1'b1;
      check_val("arvalid_o", arvalid_o, 0);
      check_val("awvalid_o", awvalid_o, 0);
      check_val("rvalid_o", rvalid_o, 0);
      check_val("wdone_o", wdone_o, 0);
    end
    for (int n = 0; n < NUM_REQS && !timed_out; n++) begin
      op_bits = 4'(rand_bits(3)) + 4'd1;
      // two cacheable windows near their edges and one uncacheable window
      case (rand_bits(2))
        0:       base = 32'h3000_0100;
        1:       base = 32'h803f_ffe0;
        default: base = 32'h4000_0000;
      endcase
      case (lsu_op_e'(op_bits))
        LSU_OP_LB, LSU_OP_LBU, LSU_OP_SB: off = 2'(rand_bits(2));
        LSU_OP_LH, LSU_OP_LHU, LSU_OP_SH: off = {1'(rand_bits(1)), 1'b0};
        default:                          off = 2'b00;
      endcase
      addr = base + (rand_bits(3) << 2) + off;
      run_req(lsu_op_e'(op_bits), addr, rand_bits(32), int'(rand_bits(2)));
    end
    foreach (shadow_mem[a]) begin
      check_val("bus memory word", bus_word(a), shadow_mem[a]);
    end
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* lsu_top.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_req_decode.sv
rtl/lsu_l1d_cache.sv
rtl/lsu_bus_ctrl.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
verification/lsu_props.sv
verification/lsu_tb.sv
